/* mul_div_pkg.sv */
// ********************
// shared widths, operation enum, issue and write-back structs
// and the helpers that classify an operation
// ********************

package mul_div_pkg;

	localparam int XLEN  = 64;
	localparam int WLEN  = 32;
	localparam int TAG_W = 5;

	// last counter values, 2 quotient bits per step
	localparam logic [4:0] DIV_ITER   = 5'd31;
	localparam logic [4:0] DIV_ITER_W = 5'd15;

	typedef logic [XLEN-1:0]  xlen_t;
	typedef logic [TAG_W-1:0] tag_t;

	typedef enum logic [3:0] {
		op_mul, op_mulh, op_mulhsu, op_mulhu, op_mulw,
		op_div, op_divu, op_rem, op_remu,
		op_divw, op_divuw, op_remw, op_remuw
	} op_t;

	typedef struct packed {
		op_t  op;
		tag_t rd;
		logic makes_rd;
	} issue_t;

	typedef struct packed {
		logic  write;
		tag_t  rd;
		xlen_t data;
	} wb_t;

	function automatic logic is_mul_op(op_t op);
		return op inside {op_mul, op_mulh, op_mulhsu, op_mulhu, op_mulw};
	endfunction

	function automatic logic is_word_op(op_t op);
		return op inside {op_mulw, op_divw, op_divuw, op_remw, op_remuw};
	endfunction

	function automatic logic is_signed_div(op_t op);
		return op inside {op_div, op_rem, op_divw, op_remw};
	endfunction

	function automatic logic is_rem_op(op_t op);
		return op inside {op_rem, op_remu, op_remw, op_remuw};
	endfunction

endpackage

/* mul_pipe.sv */
// ********************
// multiplier pipeline
// operand stage, then product stage
// ********************
`timescale 1ns/1ns

module mul_pipe
	import mul_div_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   enable,
	input  issue_t issue,
	input  xlen_t  r1,
	input  xlen_t  r2,
	output logic   mul_valid,
	output wb_t    mul_wb
);

	logic   s1_valid;
	issue_t s1_issue;
	xlen_t  s1_r1;
	xlen_t  s1_r2;
	xlen_t  product_sel;

	logic accept;
	assign accept = enable && is_mul_op(issue.op);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid  <= 1'b0;
			mul_valid <= 1'b0;
		end else begin
			s1_valid  <= accept;
			mul_valid <= s1_valid;
		end
	end

	// operand capture
	always_ff @(posedge clk) begin
		if (accept) begin
			s1_issue <= issue;
			s1_r1    <= r1;
			s1_r2    <= r2;
		end
	end

	// one 128 bit product, the extension picks the signedness
	always_comb begin
		logic          a_sgn;
		logic          b_sgn;
		logic [2*XLEN-1:0] a_ext;
		logic [2*XLEN-1:0] b_ext;
		logic [2*XLEN-1:0] prod;

		a_sgn = s1_issue.op inside {op_mul, op_mulh, op_mulhsu, op_mulw};
		b_sgn = s1_issue.op inside {op_mul, op_mulh, op_mulw};
		a_ext = {{XLEN{a_sgn & s1_r1[XLEN-1]}}, s1_r1};
		b_ext = {{XLEN{b_sgn & s1_r2[XLEN-1]}}, s1_r2};
		prod  = a_ext * b_ext;	// low 128 bits are exact
		case (s1_issue.op)
			op_mulh, op_mulhsu, op_mulhu: product_sel = prod[2*XLEN-1:XLEN];
			op_mulw: product_sel = {{WLEN{prod[WLEN-1]}}, prod[WLEN-1:0]};
			default: product_sel = prod[XLEN-1:0];
		endcase
	end

	// product stage
	always_ff @(posedge clk) begin
		mul_wb.write <= s1_issue.makes_rd;
		mul_wb.rd    <= s1_issue.rd;
		mul_wb.data  <= product_sel;
	end

endmodule

/* div_radix4_step.sv */
// ********************
// one radix-4 divide step
// ********************
`timescale 1ns/1ns

module div_radix4_step
	import mul_div_pkg::*;
(
	input  logic [2*XLEN-1:0] remainder,
	input  xlen_t             divisor,
	input  logic [XLEN+1:0]   divisor3,
	input  xlen_t             quotient,
	output logic [2*XLEN-1:0] next_remainder,
	output xlen_t             next_quotient,
	output xlen_t             partial_rem
);

	always_comb begin
		logic [XLEN+1:0] top;
		logic [XLEN+2:0] trial3;
		logic [XLEN+2:0] trial2;
		logic [XLEN+2:0] trial1;
		logic [1:0]      digit;
		xlen_t           sel;

		// partial remainder with the next two dividend bits
		top    = {remainder[2*XLEN-1:XLEN], remainder[XLEN-1:XLEN-2]};
		trial3 = {1'b0, top} - {1'b0, divisor3};
		trial2 = {1'b0, top} - {2'b0, divisor, 1'b0};
		trial1 = {1'b0, top} - {3'b0, divisor};

		if (!trial3[XLEN+2]) begin
			digit = 2'd3;
			sel   = trial3[XLEN-1:0];
		end else if (!trial2[XLEN+2]) begin
			digit = 2'd2;
			sel   = trial2[XLEN-1:0];
		end else if (!trial1[XLEN+2]) begin
			digit = 2'd1;
			sel   = trial1[XLEN-1:0];
		end else begin
			digit = 2'd0;
			sel   = top[XLEN-1:0];	// already below the divisor
		end

		next_remainder = {sel, remainder[XLEN-3:0], 2'b00};
		next_quotient  = {quotient[XLEN-3:0], digit};
		partial_rem    = sel;
	end

endmodule

/* div_unit.sv */
// ********************
// iterative divider
// setup, radix-4 iterations, sign fix-up, wait for port
// ********************
`timescale 1ns/1ns

module div_unit
	import mul_div_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   enable,
	input  issue_t issue,
	input  xlen_t  r1,
	input  xlen_t  r2,
	input  logic   div_ack,
	output logic   div_done,
	output wb_t    div_wb,
	output logic   divide_busy
);

	typedef enum logic [2:0] {st_idle, st_setup, st_iter, st_fix, st_wait} div_state_t;

	div_state_t state;

	issue_t d_issue;
	xlen_t  op_a;
	xlen_t  op_b;
	xlen_t  divisor;
	logic [XLEN+1:0]   divisor3;
	logic [2*XLEN-1:0] remainder;
	xlen_t  quotient;
	logic [$bits(DIV_ITER)-1:0] count;
	logic   negate;
	xlen_t  result;

	logic [2*XLEN-1:0] next_remainder;
	xlen_t  next_quotient;
	xlen_t  partial_rem;

	logic  start;
	logic  word;
	logic  rem;
	logic  a_neg;
	logic  b_neg;
	xlen_t a_mag;
	xlen_t b_mag;
	logic  div_zero;

	assign start = enable && !is_mul_op(issue.op);
	assign word  = is_word_op(d_issue.op);
	assign rem   = is_rem_op(d_issue.op);

	// operand magnitudes from the latched operands
	always_comb begin
		a_neg = is_signed_div(d_issue.op) && (word ? op_a[WLEN-1] : op_a[XLEN-1]);
		b_neg = is_signed_div(d_issue.op) && (word ? op_b[WLEN-1] : op_b[XLEN-1]);
		if (word) begin
			a_mag = {{WLEN{1'b0}}, a_neg ? -op_a[WLEN-1:0] : op_a[WLEN-1:0]};
			b_mag = {{WLEN{1'b0}}, b_neg ? -op_b[WLEN-1:0] : op_b[WLEN-1:0]};
		end else begin
			a_mag = a_neg ? -op_a : op_a;
			b_mag = b_neg ? -op_b : op_b;
		end
		div_zero = b_mag == '0;
	end

	div_radix4_step u_step (
		.remainder      (remainder),
		.divisor        (divisor),
		.divisor3       (divisor3),
		.quotient       (quotient),
		.next_remainder (next_remainder),
		.next_quotient  (next_quotient),
		.partial_rem    (partial_rem)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:  if (start) state <= st_setup;
				st_setup: state <= div_zero ? st_wait : st_iter;	// by zero skips the loop
				st_iter:  if (count == '0) state <= negate ? st_fix : st_wait;
				st_fix:   state <= st_wait;
				st_wait:  if (div_ack) state <= st_idle;
				default:  state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				if (start) begin
					d_issue <= issue;
					op_a    <= r1;
					op_b    <= r2;
				end
			end
			st_setup: begin
				divisor   <= b_mag;
				divisor3  <= {2'b00, b_mag} + {1'b0, b_mag, 1'b0};
				remainder <= word ? {{XLEN{1'b0}}, a_mag[WLEN-1:0], {WLEN{1'b0}}}
				                  : {{XLEN{1'b0}}, a_mag};
				quotient  <= '0;
				count     <= word ? DIV_ITER_W : DIV_ITER;
				negate    <= rem ? a_neg : a_neg ^ b_neg;	// remainder follows dividend
				result    <= rem ? op_a : '1;
			end
			st_iter: begin
				remainder <= next_remainder;
				quotient  <= next_quotient;
				count     <= count - 1'b1;
				if (count == '0)
					result <= rem ? partial_rem : next_quotient;
			end
			st_fix: result <= -result;
			default: ;
		endcase
	end

	assign div_done    = state == st_wait;
	assign divide_busy = state != st_idle;

	assign div_wb.write = d_issue.makes_rd;
	assign div_wb.rd    = d_issue.rd;
	assign div_wb.data  = word ? {{WLEN{result[WLEN-1]}}, result[WLEN-1:0]} : result;

endmodule

/* result_arbiter.sv */
// ********************
// write-back port arbiter
// multiply first, divide waits
// ********************
`timescale 1ns/1ns

module result_arbiter
	import mul_div_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic mul_valid,
	input  wb_t  mul_wb,
	input  logic div_done,
	input  wb_t  div_wb,
	output logic div_ack,
	output wb_t  wb
);

	logic  wb_write;
	tag_t  wb_rd;
	xlen_t wb_data;

	assign div_ack = div_done && !mul_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_write <= 1'b0;
		else if (mul_valid)
			wb_write <= mul_wb.write;
		else if (div_done)
			wb_write <= div_wb.write;
		else
			wb_write <= 1'b0;	// idle port
	end

	always_ff @(posedge clk) begin
		if (mul_valid) begin
			wb_rd   <= mul_wb.rd;
			wb_data <= mul_wb.data;
		end else if (div_done) begin
			wb_rd   <= div_wb.rd;
			wb_data <= div_wb.data;
		end
	end

	assign wb = '{write: wb_write, rd: wb_rd, data: wb_data};

endmodule

/* mul_div_unit.sv */
// ********************
// multiply/divide unit top
// ********************
`timescale 1ns/1ns

module mul_div_unit
	import mul_div_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   enable,
	input  issue_t issue,
	input  xlen_t  r1,
	input  xlen_t  r2,
	output wb_t    wb,
	output logic   divide_busy
);

	logic mul_valid;
	wb_t  mul_wb;
	logic div_done;
	wb_t  div_wb;
	logic div_ack;

	mul_pipe u_mul (
		.clk       (clk),
		.arst_n    (arst_n),
		.enable    (enable),
		.issue     (issue),
		.r1        (r1),
		.r2        (r2),
		.mul_valid (mul_valid),
		.mul_wb    (mul_wb)
	);

	div_unit u_div (
		.clk         (clk),
		.arst_n      (arst_n),
		.enable      (enable),
		.issue       (issue),
		.r1          (r1),
		.r2          (r2),
		.div_ack     (div_ack),
		.div_done    (div_done),
		.div_wb      (div_wb),
		.divide_busy (divide_busy)
	);

	result_arbiter u_arb (
		.clk       (clk),
		.arst_n    (arst_n),
		.mul_valid (mul_valid),
		.mul_wb    (mul_wb),
		.div_done  (div_done),
		.div_wb    (div_wb),
		.div_ack   (div_ack),
		.wb        (wb)
	);

endmodule

/* tb_mul_div_unit.sv */
// ********************
// testbench for the multiply/divide unit
// vector driven issues with random gaps, write-back checks
// ********************
`timescale 1ns/1ns

module tb_mul_div_unit
	import mul_div_pkg::*;
;

	localparam int MAX_VEC = 64;

	logic   clk;
	logic   arst_n;
	logic   enable;
	issue_t issue;
	xlen_t  r1;
	xlen_t  r2;
	wb_t    wb;
	logic   divide_busy;

	logic [207:0] vectors [0:MAX_VEC-1];
	int           num_vec;
	int           cyc;
	int           limit;
	logic [16:0]  lfsr;

	wb_t mul_exp [$];
	int  mul_due [$];
	wb_t div_exp;
	logic div_pending;
	int  div_first;
	int  div_end;

	mul_div_unit u_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.enable      (enable),
		.issue       (issue),
		.r1          (r1),
		.r2          (r2),
		.wb          (wb),
		.divide_busy (divide_busy)
	);

	always #10 clk = ~clk;

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	// cycles from issue to write-back on a free port
	function automatic int divide_latency(input op_t op, input xlen_t a, input xlen_t b);
		logic word;
		logic sgn;
		logic a_neg;
		logic b_neg;
		logic zero;
		logic fix;

		word  = op inside {op_divw, op_divuw, op_remw, op_remuw};
		sgn   = op inside {op_div, op_rem, op_divw, op_remw};
		a_neg = sgn && (word ? a[31] : a[63]);
		b_neg = sgn && (word ? b[31] : b[63]);
		zero  = word ? (b[31:0] == '0) : (b == '0);
		fix   = (op inside {op_rem, op_remw}) ? a_neg : a_neg ^ b_neg;
		if (zero)
			return 3;	// setup, then straight to the port
		return 3 + (word ? 16 : 32) + fix;
	endfunction

	task automatic check_wb(input string name, input wb_t exp, input wb_t got);
		if (got !== exp) begin
			$display("CHECK FAILED time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("CHECK FAILED time=%0t signal=%s expected=%b got=%b", $time, name, exp, got);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// compare the port after the edge, outputs settled by the falling edge
	task automatic check_port();
		if (mul_due.size() > 0 && mul_due[0] == cyc) begin
			void'(mul_due.pop_front());
			check_wb("wb (multiply)", mul_exp.pop_front(), wb);
			if (div_pending && cyc == div_end)
				div_end++;	// port taken, divide holds its result
		end else if (div_pending && cyc == div_end) begin
			check_wb("wb (divide)", div_exp, wb);
			div_pending = 1'b0;
		end else begin
			check_bit("wb.write", 1'b0, wb.write);
		end
		check_bit("divide_busy", div_pending && cyc >= div_first, divide_busy);
	endtask

	task automatic tick();
		@(posedge clk);
		cyc++;
		if (cyc > limit) begin
			$display("timeout after %0d cycles, write-backs still outstanding", cyc);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic idle_cycle();
		tick();
		enable <= 1'b0;
		@(negedge clk);
		check_port();
	endtask

	task automatic issue_vector(input logic [207:0] v);
		wb_t exp;
		logic is_mul;

		is_mul    = v[207:204] < 4'd5;
		exp.write = v[192];
		exp.rd    = v[200:196];
		exp.data  = v[63:0];
		while (!is_mul && div_pending)
			idle_cycle();
		while (is_mul && div_pending && cyc + 4 < div_end)
			idle_cycle();	// aim the product at the divide's write cycle
		tick();
		enable         <= 1'b1;
		issue.op       <= op_t'(v[207:204]);
		issue.rd       <= v[200:196];
		issue.makes_rd <= v[192];
		r1             <= v[191:128];
		r2             <= v[127:64];
		if (is_mul) begin
			mul_exp.push_back(exp);
			mul_due.push_back(cyc + 3);	// on wb three edges after this one
		end else begin
			div_exp     = exp;
			div_pending = 1'b1;
			div_first   = cyc + 1;
			div_end     = cyc + divide_latency(op_t'(v[207:204]), v[191:128], v[127:64]);
		end
		@(negedge clk);
		check_port();
	endtask

	initial begin
		logic [1:0] gap;

		clk         = 1'b0;
		arst_n      = 1'b0;
		enable      = 1'b0;
		issue       = '0;
		r1          = '0;
		r2          = '0;
		cyc         = 0;
		div_pending = 1'b0;
		div_first   = 0;
		div_end     = 0;
		lfsr        = 17'd81704;

		$readmemh("mul_div_vectors.txt", vectors);
		num_vec = 0;
		while (num_vec < MAX_VEC && !$isunknown(vectors[num_vec]))
			num_vec++;
		if (num_vec == 0) begin
			$display("no vectors could be read from mul_div_vectors.txt");
			$display("TEST FAILED");
			$fatal(1);
		end
		limit = num_vec * 45 + 100;

		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_bit("wb.write", 1'b0, wb.write);
		check_bit("divide_busy", 1'b0, divide_busy);

		for (int i = 0; i < num_vec; i++) begin
			issue_vector(vectors[i]);
			lfsr   = lfsr_step(lfsr);
			gap[0] = lfsr[0];
			lfsr   = lfsr_step(lfsr);
			gap[1] = lfsr[0];
			repeat (gap) idle_cycle();
		end

		// drain what is still in flight
		while (mul_due.size() > 0 || div_pending)
			idle_cycle();
		repeat (2) idle_cycle();

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* mul_div_vectors.txt */
// op_rd_makesrd_r1_r2_expected, all hex, op 0..c = mul mulh mulhsu mulhu mulw div divu rem remu
// divw divuw remw remuw, rd is two digits and makes_rd one digit
0_01_1_0000000000000007_FFFFFFFFFFFFFFFD_FFFFFFFFFFFFFFEB
1_02_1_8000000000000000_0000000000000002_FFFFFFFFFFFFFFFF
5_03_1_FFFFFFFFFFFFFFF9_0000000000000002_FFFFFFFFFFFFFFFD
0_04_1_0000000012345678_0000000000000010_0000000123456780
2_05_1_FFFFFFFFFFFFFFFF_FFFFFFFFFFFFFFFF_FFFFFFFFFFFFFFFF
3_06_1_FFFFFFFFFFFFFFFF_FFFFFFFFFFFFFFFF_FFFFFFFFFFFFFFFE
4_07_1_0000000000010000_0000000000008000_FFFFFFFF80000000
7_08_1_FFFFFFFFFFFFFFF9_0000000000000002_FFFFFFFFFFFFFFFF
4_09_0_0000000000000003_0000000000000005_000000000000000F
0_0A_1_FFFFFFFFFFFFFFFF_FFFFFFFFFFFFFFFF_0000000000000001
6_0B_1_0000000000000064_0000000000000007_000000000000000E
8_0C_1_0000000000000064_0000000000000007_0000000000000002
7_0D_1_0000000000000007_FFFFFFFFFFFFFFFD_0000000000000001
5_0E_1_0000000000000007_FFFFFFFFFFFFFFFD_FFFFFFFFFFFFFFFE
5_0F_1_000000000000002A_0000000000000000_FFFFFFFFFFFFFFFF
8_10_1_000000000000002A_0000000000000000_000000000000002A
5_11_1_8000000000000000_FFFFFFFFFFFFFFFF_8000000000000000
7_12_1_8000000000000000_FFFFFFFFFFFFFFFF_0000000000000000
9_13_1_12345678FFFFFFF0_0000000000000003_FFFFFFFFFFFFFFFB
0_14_1_0000000000000002_0000000000000003_0000000000000006
A_15_1_00000000FFFFFFF0_0000000000000003_0000000055555550
B_16_1_00000000FFFFFFF0_0000000000000003_FFFFFFFFFFFFFFFF
C_17_1_00000000FFFFFFF0_0000000000000007_0000000000000002
A_18_0_0000000000000064_000000000000000A_000000000000000A

/* all.f */
mul_div_pkg.sv
mul_pipe.sv
div_radix4_step.sv
div_unit.sv
result_arbiter.sv
mul_div_unit.sv
tb_mul_div_unit.sv

/* Bender.yml */
package:
  name: mul_div_unit

sources:
  - files:
      - mul_div_pkg.sv
      - mul_pipe.sv
      - div_radix4_step.sv
      - div_unit.sv
      - result_arbiter.sv
      - mul_div_unit.sv
  - target: test
    files:
      - tb_mul_div_unit.sv
